// ==== common/lane_pkg.sv ====
////////////////////
// Vector lane package
////////////////////

package lane_pkg;

  ////////////////////
  // Sizes

  // Element and register file geometry
  parameter int unsigned ElemWidth = 32;
  parameter int unsigned NrVRegs   = 8;
  parameter int unsigned NrElems   = 8;

  parameter int unsigned VRegIdxW  = $clog2(NrVRegs);
  parameter int unsigned ElemIdxW  = $clog2(NrElems);

  // Operand queue depth used unless the top level overrides it
  parameter int unsigned DefaultQueueDepth = 4;

  ////////////////////
  // Types

  typedef logic [ElemWidth-1:0] elen_t;
  typedef logic [VRegIdxW-1:0]  vreg_idx_t;
  typedef logic [ElemIdxW-1:0]  elem_idx_t;

  // Vector length 1..NrElems, one bit wider than an element index
  typedef logic [ElemIdxW:0] vlen_t;

  // Element address, register number in the upper bits
  typedef logic [VRegIdxW+ElemIdxW-1:0] vaddr_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_STORE
  } lane_op_e;

endpackage : lane_pkg

// ==== common/operand_if.sv ====
////////////////////
// Operand pair link
////////////////////

`timescale 1ns/10ps

interface operand_if;

  logic                 valid;
  logic                 ready;
  lane_pkg::lane_op_e   op;
  lane_pkg::vreg_idx_t  vd;
  lane_pkg::elem_idx_t  elem;
  // opa comes from vs1, opb from vs2
  lane_pkg::elen_t      opa;
  lane_pkg::elen_t      opb;
  logic                 last;

  modport source (
    output valid, op, vd, elem, opa, opb, last,
    input  ready
  );

  modport sink (
    input  valid, op, vd, elem, opa, opb, last,
    output ready
  );

endinterface : operand_if

// ==== vrf/vector_regfile.sv ====
////////////////////
// Vector register file
////////////////////

`timescale 1ns/10ps

module vector_regfile (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Read port
  input  logic             rd_en_i,
  input  lane_pkg::vaddr_t rd_addr_a_i,
  input  lane_pkg::vaddr_t rd_addr_b_i,
  output lane_pkg::elen_t  rd_data_a_o,
  output lane_pkg::elen_t  rd_data_b_o,
  // ALU write
  input  logic             wr_en_i,
  input  lane_pkg::vaddr_t wr_addr_i,
  input  lane_pkg::elen_t  wr_data_i,
  // Load write
  input  logic             ldu_req_i,
  input  lane_pkg::vaddr_t ldu_addr_i,
  input  lane_pkg::elen_t  ldu_wdata_i,
  output logic             ldu_gnt_o
);

  localparam int unsigned NrWords = lane_pkg::NrVRegs * lane_pkg::NrElems;

  lane_pkg::elen_t  mem_q [NrWords];

  logic             we;
  lane_pkg::vaddr_t waddr;
  lane_pkg::elen_t  wdata;

  // ALU has priority on the single write port
  assign ldu_gnt_o = ldu_req_i & ~wr_en_i;
  assign we        = wr_en_i | ldu_gnt_o;
  assign waddr     = wr_en_i ? wr_addr_i : ldu_addr_i;
  assign wdata     = wr_en_i ? wr_data_i : ldu_wdata_i;

  // Register file starts out cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NrWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we) begin
      mem_q[waddr] <= wdata;
    end
  end

  // Registered reads, held while no read is issued
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_a_o <= mem_q[rd_addr_a_i];
      rd_data_b_o <= mem_q[rd_addr_b_i];
    end
  end

endmodule : vector_regfile

// ==== rtl/operand_requester.sv ====
////////////////////
// Operand requester
////////////////////

`timescale 1ns/10ps

module operand_requester (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Sequencer
  input  logic                req_valid_i,
  input  lane_pkg::lane_op_e  req_op_i,
  input  lane_pkg::vreg_idx_t req_vs1_i,
  input  lane_pkg::vreg_idx_t req_vs2_i,
  input  lane_pkg::vreg_idx_t req_vd_i,
  input  lane_pkg::vlen_t     req_vl_i,
  output logic                req_ready_o,
  input  logic                vinsn_done_i,
  // VRF read port
  output logic                rd_en_o,
  output lane_pkg::vaddr_t    rd_addr_a_o,
  output lane_pkg::vaddr_t    rd_addr_b_o,
  input  lane_pkg::elen_t     rd_data_a_i,
  input  lane_pkg::elen_t     rd_data_b_i,
  // Towards the operand queue
  operand_if.source           opq
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_DONE
  } state_e;

  state_e              state_q;
  lane_pkg::elem_idx_t elem_cnt_q;
  logic                last_elem;

  // Latched instruction
  lane_pkg::lane_op_e  op_q;
  lane_pkg::vreg_idx_t vs1_q;
  lane_pkg::vreg_idx_t vs2_q;
  lane_pkg::vreg_idx_t vd_q;
  lane_pkg::vlen_t     vl_q;

  // Tag of the read in flight, paired with the VRF data
  logic                pend_valid_q;
  lane_pkg::lane_op_e  pend_op_q;
  lane_pkg::vreg_idx_t pend_vd_q;
  lane_pkg::elem_idx_t pend_elem_q;
  logic                pend_last_q;

  assign req_ready_o = (state_q == IDLE);
  assign rd_en_o     = (state_q == ISSUE) && opq.ready;
  assign rd_addr_a_o = {vs1_q, elem_cnt_q};
  assign rd_addr_b_o = {vs2_q, elem_cnt_q};
  assign last_elem   = ({1'b0, elem_cnt_q} == (vl_q - 1'b1));

  ////////////////////
  // Control FSM

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      elem_cnt_q   <= '0;
      pend_valid_q <= 1'b0;
    end else begin
      // A stalled item keeps its valid, the VRF holds its data
      pend_valid_q <= rd_en_o | (pend_valid_q & ~opq.ready);
      unique case (state_q)
        IDLE: begin
          if (req_valid_i) begin
            state_q    <= ISSUE;
            elem_cnt_q <= '0;
          end
        end
        ISSUE: begin
          if (rd_en_o) begin
            elem_cnt_q <= elem_cnt_q + 1'b1;
            if (last_elem) begin
              state_q <= WAIT_DONE;
            end
          end
        end
        WAIT_DONE: begin
          if (vinsn_done_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      op_q  <= req_op_i;
      vs1_q <= req_vs1_i;
      vs2_q <= req_vs2_i;
      vd_q  <= req_vd_i;
      vl_q  <= req_vl_i;
    end
    if (rd_en_o) begin
      pend_op_q   <= op_q;
      pend_vd_q   <= vd_q;
      pend_elem_q <= elem_cnt_q;
      pend_last_q <= last_elem;
    end
  end

  assign opq.valid = pend_valid_q;
  assign opq.op    = pend_op_q;
  assign opq.vd    = pend_vd_q;
  assign opq.elem  = pend_elem_q;
  assign opq.opa   = rd_data_a_i;
  assign opq.opb   = rd_data_b_i;
  assign opq.last  = pend_last_q;

endmodule : operand_requester

// ==== rtl/operand_queue.sv ====
////////////////////
// Operand queue
////////////////////

`timescale 1ns/10ps

module operand_queue #(
  parameter int unsigned QueueDepth = lane_pkg::DefaultQueueDepth
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  operand_if.sink   in_q,
  operand_if.source out_q
);

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  typedef struct packed {
    lane_pkg::lane_op_e  op;
    lane_pkg::vreg_idx_t vd;
    lane_pkg::elem_idx_t elem;
    lane_pkg::elen_t     opa;
    lane_pkg::elen_t     opb;
    logic                last;
  } item_t;

  item_t           mem_q [QueueDepth];
  item_t           head;
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push;
  logic            pop;

  // Keep room for the VRF read already in flight
  assign in_q.ready  = (cnt_q <= CntW'(QueueDepth - 2));
  assign out_q.valid = (cnt_q != '0);

  assign push = in_q.valid & in_q.ready;
  assign pop  = out_q.valid & out_q.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= '{op:   in_q.op,
                           vd:   in_q.vd,
                           elem: in_q.elem,
                           opa:  in_q.opa,
                           opb:  in_q.opb,
                           last: in_q.last};
    end
  end

  assign head       = mem_q[rd_ptr_q];
  assign out_q.op   = head.op;
  assign out_q.vd   = head.vd;
  assign out_q.elem = head.elem;
  assign out_q.opa  = head.opa;
  assign out_q.opb  = head.opb;
  assign out_q.last = head.last;

endmodule : operand_queue

// ==== rtl/lane_alu.sv ====
////////////////////
// Lane ALU
////////////////////

`timescale 1ns/10ps

module lane_alu (
  input  logic             clk_i,
  input  logic             rst_ni,
  operand_if.sink          opq,
  // VRF write port
  output logic             wr_en_o,
  output lane_pkg::vaddr_t wr_addr_o,
  output lane_pkg::elen_t  wr_data_o,
  // Store unit
  output lane_pkg::elen_t  stu_operand_o,
  output logic             stu_operand_valid_o,
  input  logic             stu_operand_ready_i,
  output logic             vinsn_done_o
);

  logic            is_store;
  logic            xfer;
  lane_pkg::elen_t result;

  assign is_store = (opq.op == lane_pkg::OP_STORE);

  // Only stores can be back-pressured
  assign opq.ready = is_store ? stu_operand_ready_i : 1'b1;
  assign xfer      = opq.valid & opq.ready;

  ////////////////////
  // Element datapath

  always_comb begin
    unique case (opq.op)
      lane_pkg::OP_ADD: result = opq.opb + opq.opa;
      // vs2 minus vs1
      lane_pkg::OP_SUB: result = opq.opb - opq.opa;
      lane_pkg::OP_AND: result = opq.opb & opq.opa;
      lane_pkg::OP_OR:  result = opq.opb | opq.opa;
      lane_pkg::OP_XOR: result = opq.opb ^ opq.opa;
      default:          result = opq.opb;
    endcase
  end

  assign wr_en_o   = opq.valid & ~is_store;
  assign wr_addr_o = {opq.vd, opq.elem};
  assign wr_data_o = result;

  ////////////////////
  // Store stream

  // Queue head stays put while the store unit stalls
  assign stu_operand_valid_o = opq.valid & is_store;
  assign stu_operand_o       = opq.opb;

  // One pulse as the last element leaves
  assign vinsn_done_o = xfer & opq.last;

endmodule : lane_alu

// ==== rtl/lane_top.sv ====
////////////////////
// Vector lane top
////////////////////

`timescale 1ns/10ps

module lane_top #(
  parameter int unsigned QueueDepth = lane_pkg::DefaultQueueDepth
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Sequencer
  input  logic                req_valid_i,
  input  lane_pkg::lane_op_e  req_op_i,
  input  lane_pkg::vreg_idx_t req_vs1_i,
  input  lane_pkg::vreg_idx_t req_vs2_i,
  input  lane_pkg::vreg_idx_t req_vd_i,
  input  lane_pkg::vlen_t     req_vl_i,
  output logic                req_ready_o,
  output logic                vinsn_done_o,
  // Load unit
  input  logic                ldu_req_i,
  input  lane_pkg::vaddr_t    ldu_addr_i,
  input  lane_pkg::elen_t     ldu_wdata_i,
  output logic                ldu_gnt_o,
  // Store unit
  output lane_pkg::elen_t     stu_operand_o,
  output logic                stu_operand_valid_o,
  input  logic                stu_operand_ready_i
);

  // VRF read port
  logic             rd_en;
  lane_pkg::vaddr_t rd_addr_a;
  lane_pkg::vaddr_t rd_addr_b;
  lane_pkg::elen_t  rd_data_a;
  lane_pkg::elen_t  rd_data_b;

  // VRF write port from the ALU
  logic             wr_en;
  lane_pkg::vaddr_t wr_addr;
  lane_pkg::elen_t  wr_data;

  logic             vinsn_done;

  operand_if req_opq ();
  operand_if alu_opq ();

  assign vinsn_done_o = vinsn_done;

  ////////////////////
  // Operand fetch

  operand_requester i_requester (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_vs1_i   (req_vs1_i),
    .req_vs2_i   (req_vs2_i),
    .req_vd_i    (req_vd_i),
    .req_vl_i    (req_vl_i),
    .req_ready_o (req_ready_o),
    .vinsn_done_i(vinsn_done),
    .rd_en_o     (rd_en),
    .rd_addr_a_o (rd_addr_a),
    .rd_addr_b_o (rd_addr_b),
    .rd_data_a_i (rd_data_a),
    .rd_data_b_i (rd_data_b),
    .opq         (req_opq.source)
  );

  operand_queue #(
    .QueueDepth(QueueDepth)
  ) i_queue (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .in_q  (req_opq.sink),
    .out_q (alu_opq.source)
  );

  ////////////////////
  // Execute and storage

  lane_alu i_alu (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .opq                (alu_opq.sink),
    .wr_en_o            (wr_en),
    .wr_addr_o          (wr_addr),
    .wr_data_o          (wr_data),
    .stu_operand_o      (stu_operand_o),
    .stu_operand_valid_o(stu_operand_valid_o),
    .stu_operand_ready_i(stu_operand_ready_i),
    .vinsn_done_o       (vinsn_done)
  );

  vector_regfile i_vrf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_en_i    (rd_en),
    .rd_addr_a_i(rd_addr_a),
    .rd_addr_b_i(rd_addr_b),
    .rd_data_a_o(rd_data_a),
    .rd_data_b_o(rd_data_b),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .ldu_req_i  (ldu_req_i),
    .ldu_addr_i (ldu_addr_i),
    .ldu_wdata_i(ldu_wdata_i),
    .ldu_gnt_o  (ldu_gnt_o)
  );

endmodule : lane_top

// ==== testbench/tb_clock.sv ====
////////////////////
// Testbench clock and reset
////////////////////

`timescale 1ns/10ps

module tb_clock #(
  parameter int unsigned PeriodNs    = 20,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release reset away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule : tb_clock

// ==== testbench/tb_lane.sv ====
////////////////////
// Vector lane testbench
////////////////////

`timescale 1ns/10ps

module tb_lane;

  localparam int unsigned NrWords = lane_pkg::NrVRegs * lane_pkg::NrElems;
  localparam int unsigned Timeout = 200;

  logic                clk;
  logic                rst_n;
  logic                req_valid;
  lane_pkg::lane_op_e  req_op;
  lane_pkg::vreg_idx_t req_vs1;
  lane_pkg::vreg_idx_t req_vs2;
  lane_pkg::vreg_idx_t req_vd;
  lane_pkg::vlen_t     req_vl;
  logic                req_ready;
  logic                vinsn_done;
  logic                ldu_req;
  lane_pkg::vaddr_t    ldu_addr;
  lane_pkg::elen_t     ldu_wdata;
  logic                ldu_gnt;
  lane_pkg::elen_t     stu_operand;
  logic                stu_valid;
  logic                stu_ready;

  // Reference copy of the register file
  lane_pkg::elen_t model_mem [NrWords];
  lane_pkg::elen_t stu_seen [$];
  int unsigned     rng_state;
  int unsigned     err_cnt;
  int unsigned     test_err_base;
  int unsigned     test_num;
  int unsigned     tests_passed;
  int unsigned     tests_failed;

  tb_clock #(.PeriodNs(20), .ResetCycles(16)) i_clock (.clk_o(clk), .rst_no(rst_n));

  lane_top #(.QueueDepth(4)) DUT (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .req_valid_i        (req_valid),
    .req_op_i           (req_op),
    .req_vs1_i          (req_vs1),
    .req_vs2_i          (req_vs2),
    .req_vd_i           (req_vd),
    .req_vl_i           (req_vl),
    .req_ready_o        (req_ready),
    .vinsn_done_o       (vinsn_done),
    .ldu_req_i          (ldu_req),
    .ldu_addr_i         (ldu_addr),
    .ldu_wdata_i        (ldu_wdata),
    .ldu_gnt_o          (ldu_gnt),
    .stu_operand_o      (stu_operand),
    .stu_operand_valid_o(stu_valid),
    .stu_operand_ready_i(stu_ready)
  );

  ////////////////////
  // Helpers

  function automatic int unsigned next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  // Upper LCG bits only, the low ones repeat quickly
  function automatic int unsigned rand_below(int unsigned n);
    return (next_rand() >> 16) % n;
  endfunction

  function automatic lane_pkg::elen_t rand_word();
    int unsigned hi;
    int unsigned lo;
    hi = next_rand() >> 16;
    lo = next_rand() >> 16;
    return lane_pkg::elen_t'((hi << 16) | lo);
  endfunction

  // a is the vs1 element, b the vs2 element
  function automatic lane_pkg::elen_t expected_elem(lane_pkg::lane_op_e op,
                                                    lane_pkg::elen_t a, lane_pkg::elen_t b);
    case (op)
      lane_pkg::OP_ADD: return b + a;
      lane_pkg::OP_SUB: return b - a;
      lane_pkg::OP_AND: return b & a;
      lane_pkg::OP_OR:  return b | a;
      lane_pkg::OP_XOR: return b ^ a;
      default:          return b;
    endcase
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
    $display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
    err_cnt++;
  endtask

  task automatic report_error(string msg);
    $display("Error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic stop_on_timeout(string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic start_test();
    test_err_base = err_cnt;
    test_num++;
  endtask

  task automatic finish_test(string name);
    if (err_cnt == test_err_base) begin
      $display("Test %0d %s: passed", test_num, name);
      tests_passed++;
    end else begin
      $display("Test %0d %s: failed with %0d errors", test_num, name, err_cnt - test_err_base);
      tests_failed++;
    end
  endtask

  ////////////////////
  // Load and instruction drivers

  // The lane is idle here, so every request must be granted at once
  task automatic load_word(lane_pkg::vaddr_t addr, lane_pkg::elen_t data);
    @(posedge clk);
    ldu_req   <= 1'b1;
    ldu_addr  <= addr;
    ldu_wdata <= data;
    @(negedge clk);
    if (ldu_gnt !== 1'b1) report_mismatch("ldu_gnt_o", 32'(ldu_gnt), 32'd1);
    if (ldu_gnt === 1'b1) model_mem[addr] = data;
  endtask

  task automatic end_loads();
    @(posedge clk);
    ldu_req <= 1'b0;
  endtask

  task automatic run_insn(lane_pkg::lane_op_e op, lane_pkg::vreg_idx_t vs1,
                          lane_pkg::vreg_idx_t vs2, lane_pkg::vreg_idx_t vd,
                          lane_pkg::vlen_t vl, bit stall, bit hold);
    int unsigned     waited;
    int unsigned     exp_cnt;
    int unsigned     idx;
    bit              pending;
    bit              done;
    lane_pkg::elen_t held;

    stu_seen.delete();
    pending = 1'b0;
    done    = 1'b0;
    held    = '0;
    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= op;
    req_vs1   <= vs1;
    req_vs2   <= vs2;
    req_vd    <= vd;
    req_vl    <= vl;
    stu_ready <= 1'b1;
    @(negedge clk);
    // Previous pulse is over and the lane is free again
    if (vinsn_done !== 1'b0) report_mismatch("vinsn_done_o", 32'(vinsn_done), 32'd0);
    if (req_ready !== 1'b1) report_mismatch("req_ready_o", 32'(req_ready), 32'd1);
    waited = 0;
    while (req_ready !== 1'b1) begin
      waited++;
      if (waited > Timeout) stop_on_timeout("req_ready_o");
      @(negedge clk);
    end
    @(posedge clk);
    if (!hold) req_valid <= 1'b0;
    waited = 0;
    while (!done) begin
      if (stall) stu_ready <= (rand_below(3) != 0);
      @(negedge clk);
      if (pending) begin
        if (stu_valid !== 1'b1) report_error("store element withdrawn while stalled");
        if (stu_operand !== held) report_mismatch("stu_operand_o", stu_operand, held);
      end
      pending = 1'b0;
      if (stu_valid === 1'b1) begin
        if (stu_ready) begin
          stu_seen.push_back(stu_operand);
        end else begin
          pending = 1'b1;
          held    = stu_operand;
        end
      end
      // No new instruction may be taken while this one runs
      if (req_ready !== 1'b0) report_mismatch("req_ready_o", 32'(req_ready), 32'd0);
      if (vinsn_done === 1'b1) done = 1'b1;
      waited++;
      if (!done && waited > Timeout) stop_on_timeout("vinsn_done_o");
      if (!done) @(posedge clk);
    end
    if (!hold) begin
      @(posedge clk);
      stu_ready <= 1'b1;
      @(negedge clk);
      if (vinsn_done !== 1'b0) report_error("vinsn_done_o lasted more than one cycle");
    end

    exp_cnt = (op == lane_pkg::OP_STORE) ? int'(vl) : 0;
    if (stu_seen.size() != exp_cnt) begin
      report_error($sformatf("store stream gave %0d elements, expected %0d",
                             stu_seen.size(), exp_cnt));
    end
    for (idx = 0; idx < stu_seen.size() && idx < exp_cnt; idx++) begin
      if (stu_seen[idx] !== model_mem[vs2 * lane_pkg::NrElems + idx]) begin
        report_mismatch("stu_operand_o", stu_seen[idx],
                        model_mem[vs2 * lane_pkg::NrElems + idx]);
      end
    end
    if (op != lane_pkg::OP_STORE) begin
      for (idx = 0; idx < vl; idx++) begin
        model_mem[vd * lane_pkg::NrElems + idx] =
          expected_elem(op, model_mem[vs1 * lane_pkg::NrElems + idx],
                        model_mem[vs2 * lane_pkg::NrElems + idx]);
      end
    end
  endtask

  ////////////////////
  // Test sequence

  initial begin
    int unsigned         waited;
    int unsigned         idx;
    lane_pkg::lane_op_e  op;
    lane_pkg::vreg_idx_t vs1;
    lane_pkg::vreg_idx_t vs2;
    lane_pkg::vreg_idx_t vd;
    lane_pkg::vreg_idx_t vd2;
    lane_pkg::vlen_t     vl;

    rng_state    = 44924;
    err_cnt      = 0;
    test_num     = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (idx = 0; idx < NrWords; idx++) model_mem[idx] = '0;
    req_valid <= 1'b0;
    req_op    <= lane_pkg::OP_ADD;
    req_vs1   <= '0;
    req_vs2   <= '0;
    req_vd    <= '0;
    req_vl    <= '0;
    ldu_req   <= 1'b0;
    ldu_addr  <= '0;
    ldu_wdata <= '0;
    stu_ready <= 1'b1;

    waited = 0;
    while (rst_n !== 1'b1) begin
      waited++;
      if (waited > 100) stop_on_timeout("reset release");
      @(posedge clk);
    end

    start_test();
    @(negedge clk);
    if (req_ready !== 1'b1) report_mismatch("req_ready_o", 32'(req_ready), 32'd1);
    if (vinsn_done !== 1'b0) report_mismatch("vinsn_done_o", 32'(vinsn_done), 32'd0);
    if (stu_valid !== 1'b0) report_mismatch("stu_operand_valid_o", 32'(stu_valid), 32'd0);
    if (ldu_gnt !== 1'b0) report_mismatch("ldu_gnt_o", 32'(ldu_gnt), 32'd0);
    finish_test("reset state");

    // Fill every word, then overwrite a few at random
    start_test();
    for (idx = 0; idx < NrWords; idx++) load_word(lane_pkg::vaddr_t'(idx), rand_word());
    for (idx = 0; idx < 16; idx++) begin
      load_word(lane_pkg::vaddr_t'(rand_below(NrWords)), rand_word());
    end
    end_loads();
    for (idx = 0; idx < lane_pkg::NrVRegs; idx++) begin
      run_insn(lane_pkg::OP_STORE, '0, lane_pkg::vreg_idx_t'(idx), '0,
               lane_pkg::vlen_t'(lane_pkg::NrElems), 1'b0, 1'b0);
    end
    finish_test("loads and full stores");

    start_test();
    for (idx = 0; idx < 20; idx++) begin
      op  = lane_pkg::lane_op_e'(3'(rand_below(5)));
      vs1 = lane_pkg::vreg_idx_t'(rand_below(lane_pkg::NrVRegs));
      vs2 = lane_pkg::vreg_idx_t'(rand_below(lane_pkg::NrVRegs));
      vd  = lane_pkg::vreg_idx_t'(rand_below(lane_pkg::NrVRegs));
      vl  = lane_pkg::vlen_t'(1 + rand_below(lane_pkg::NrElems));
      run_insn(op, vs1, vs2, vd, vl, 1'b0, 1'b0);
      // Whole register, so the tail above vl is checked too
      run_insn(lane_pkg::OP_STORE, '0, vd, '0, lane_pkg::vlen_t'(lane_pkg::NrElems),
               1'b0, 1'b0);
    end
    finish_test("arithmetic");

    start_test();
    for (idx = 0; idx < 12; idx++) begin
      vs2 = lane_pkg::vreg_idx_t'(rand_below(lane_pkg::NrVRegs));
      vl  = lane_pkg::vlen_t'(1 + rand_below(lane_pkg::NrElems));
      run_insn(lane_pkg::OP_STORE, '0, vs2, '0, vl, 1'b1, 1'b0);
    end
    finish_test("store back-pressure");

    // Second instruction reads the vd of the first
    start_test();
    for (idx = 0; idx < 6; idx++) begin
      op  = lane_pkg::lane_op_e'(3'(rand_below(5)));
      vs1 = lane_pkg::vreg_idx_t'(rand_below(lane_pkg::NrVRegs));
      vs2 = lane_pkg::vreg_idx_t'(rand_below(lane_pkg::NrVRegs));
      vd  = lane_pkg::vreg_idx_t'(rand_below(lane_pkg::NrVRegs));
      vl  = lane_pkg::vlen_t'(1 + rand_below(lane_pkg::NrElems));
      run_insn(op, vs1, vs2, vd, vl, 1'b0, 1'b1);
      op  = lane_pkg::lane_op_e'(3'(rand_below(5)));
      vs2 = lane_pkg::vreg_idx_t'(rand_below(lane_pkg::NrVRegs));
      vd2 = lane_pkg::vreg_idx_t'(rand_below(lane_pkg::NrVRegs));
      vl  = lane_pkg::vlen_t'(1 + rand_below(lane_pkg::NrElems));
      run_insn(op, vd, vs2, vd2, vl, 1'b0, 1'b1);
      run_insn(lane_pkg::OP_STORE, '0, vd2, '0, lane_pkg::vlen_t'(lane_pkg::NrElems),
               1'b1, 1'b0);
    end
    finish_test("back-to-back chains");

    $display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
             tests_passed, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_lane

// ==== build.f ====
common/lane_pkg.sv
common/operand_if.sv
vrf/vector_regfile.sv
rtl/operand_requester.sv
rtl/operand_queue.sv
rtl/lane_alu.sv
rtl/lane_top.sv
testbench/tb_clock.sv
testbench/tb_lane.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the vector lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_lane \
  -f build.f --Mdir obj_dir -o tb_lane_sim

./obj_dir/tb_lane_sim | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
  exit 0
else
  exit 1
fi
